//--- hmc_flit_user.f
design/hmc_pkt_pkg.sv
design/hmc_axi_pkg.sv
design/hmc_link_startup.sv
design/hmc_req_packer.sv
design/hmc_rsp_unpacker.sv
design/hmc_flit_user.sv
verif/tb_clock_gen.sv
verif/hmc_flit_user_tb.sv

//--- Makefile
# Verilator simulation of the HMC flit user engine

TOP  := hmc_flit_user_tb
SRCS := $(shell cat hmc_flit_user.f)

.PHONY: all run clean

all: run

# Simulator binary, rebuilt only when a source or the file list changes
obj_dir/V$(TOP): hmc_flit_user.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  --top-module $(TOP) -f hmc_flit_user.f -o V$(TOP)

# The log decides the result, the simulator status is not trusted through the pipe
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- verif/hmc_flit_user_tb.sv
// Testbench for the HMC flit user engine covering startup, request packing and response unpacking
`timescale 1ns/1ps
`default_nettype none

module hmc_flit_user_tb;
  import hmc_pkt_pkg::*;
  import hmc_axi_pkg::*;

  // Startup needs about 270 cycles and traffic about 40, so this leaves a wide margin
  localparam int MAX_CYCLES = 2000;

  logic                   CLK, RST;
  logic                   post_done, tx_ready, rx_ready, req_ready;
  logic                   wr_req, rd_req;
  logic [ADDR_W-1:0]      wr_addr, rd_addr;
  logic [DATA_W-1:0]      wr_data;
  logic [TAG_W-1:0]       rd_tag;
  logic [3:0]             error_resp;
  axis_word_t             tx_w, rx_w;
  rd_rsp_t                rsp;
  // Link model state and expected outputs
  axis_word_t             exp_tx;
  rd_rsp_t                exp_rsp, rsp_next;
  logic                   exp_req_rdy, exp_rx_rdy, rdy_next;
  logic [3:0]             exp_err;
  int                     settle_cnt;
  logic                   wait_rdy, enabled;
  int                     cycle_cnt = 0;
  logic                   failed = 1'b0;
  logic [2:0][FLIT_W-1:0] fa, fb;
  rd_rsp_t                ra, rb;

  tb_clock_gen u_clk (.CLK(CLK), .RST(RST));

  hmc_flit_user uut (
    .CLK(CLK), .RST(RST), .post_done_i(post_done),
    .tx_o(tx_w), .tx_ready_i(tx_ready), .rx_i(rx_w), .rx_ready_o(rx_ready),
    .wr_req_i(wr_req), .wr_addr_i(wr_addr), .wr_data_i(wr_data),
    .rd_req_i(rd_req), .rd_addr_i(rd_addr), .rd_tag_i(rd_tag),
    .req_ready_o(req_ready), .rsp_o(rsp), .error_resp_o(error_resp)
  );

  // ---------------------------------------------------------------------------
  // Link model
  // ---------------------------------------------------------------------------
  // Request header, cube and reserved fields zero, address in 32-byte units
  function automatic logic [63:0] req_header(input logic [ADDR_W-1:0] addr,
      input logic [TAG_W-1:0] tag, input logic [3:0] lng, input logic [5:0] cmd);
    return {6'd0, 2'd0, addr, 5'd0, tag, lng, lng, 1'b0, cmd};
  endfunction

  function automatic axis_word_t tx_word(input logic wr, input logic [ADDR_W-1:0] waddr,
      input logic [DATA_W-1:0] wdata, input logic rd, input logic [ADDR_W-1:0] raddr,
      input logic [TAG_W-1:0] rtag);
    axis_word_t w;
    w       = '0;
    w.valid = wr | rd;
    if (wr) begin
      w.data[0].raw = {wdata[63:0], req_header(waddr, WR_TAG, LNG_WR32, CMD_P_WR32)};
      w.data[1].raw = wdata[191:64];
      w.data[2].raw = {64'd0, wdata[255:192]};
      w.user.flit_valid[2:0] = 3'b111;
      w.user.flit_hdr[0]     = 1'b1;
      w.user.flit_tail[2]    = 1'b1;
    end
    if (rd) begin
      w.data[3].raw = {64'd0, req_header(raddr, rtag, LNG_RD32, CMD_RD32)};
      w.user.flit_valid[3] = 1'b1;
      w.user.flit_hdr[3]   = 1'b1;
      w.user.flit_tail[3]  = 1'b1;
    end
    return w;
  endfunction

  always @(posedge CLK) begin
    if (RST) begin
      settle_cnt  <= 0;
      wait_rdy    <= 1'b0;
      enabled     <= 1'b0;
      exp_req_rdy <= 1'b0;
      exp_tx      <= '0;
      exp_rsp     <= '0;
      exp_rx_rdy  <= 1'b0;
      exp_err     <= '0;
    end else begin
      // Settle cycles count only while self-test done is high
      if (!wait_rdy && !enabled && post_done) begin
        settle_cnt <= settle_cnt + 1;
        if (settle_cnt == STARTUP_WAIT - 1) wait_rdy <= 1'b1;
      end
      if (wait_rdy && tx_ready) begin
        wait_rdy <= 1'b0;
        enabled  <= 1'b1;
      end
      exp_req_rdy <= enabled && tx_ready;
      exp_tx      <= enabled ? tx_word(wr_req, wr_addr, wr_data, rd_req, rd_addr, rd_tag) : '0;
      exp_rsp     <= rsp_next;
      exp_rx_rdy  <= rdy_next;
      if (rx_w.valid) exp_err <= rx_w.user.err_rsp;
    end
  end

  // Random read response as header, middle and tail flit, tail carries CRC noise
  task automatic make_rsp(output logic [2:0][FLIT_W-1:0] f, output rd_rsp_t r);
    logic [DATA_W-1:0]    data;
    logic [TAG_W-1:0]     tag;
    logic [ERRSTAT_W-1:0] es;
    data = {$urandom, $urandom, $urandom, $urandom, $urandom, $urandom, $urandom, $urandom};
    tag  = TAG_W'($urandom);
    es   = ERRSTAT_W'($urandom);
    f[0] = {data[63:0], 40'd0, tag, 4'd3, 4'd3, 1'b0, 6'b111000};
    f[1] = data[191:64];
    f[2] = {$urandom, 5'd0, es, 20'd0, data[255:192]};
    r.valid   = 1'b1;
    r.tag     = tag;
    r.data    = data;
    r.errstat = es;
  endtask

  // ---------------------------------------------------------------------------
  // Stimulus tasks, each one clock cycle
  // ---------------------------------------------------------------------------
  task automatic idle_cycle(input rd_rsp_t exp);
    wr_req   <= 1'b0;
    rd_req   <= 1'b0;
    rx_w     <= '0;
    rsp_next <= exp;
    rdy_next <= 1'b1;
    @(posedge CLK);
  endtask

  task automatic send_req(input logic wr, input logic rd);
    wr_req  <= wr;
    wr_addr <= ADDR_W'($urandom);
    wr_data <= {$urandom, $urandom, $urandom, $urandom, $urandom, $urandom, $urandom,
                $urandom};
    rd_req  <= rd;
    rd_addr <= ADDR_W'($urandom);
    rd_tag  <= TAG_W'($urandom);
    @(posedge CLK);
  endtask

  task automatic send_word(input logic [3:0][FLIT_W-1:0] fl, input logic [3:0] vld,
      input logic [3:0] hdr, input logic [3:0] tl, input rd_rsp_t exp, input logic rdy);
    axis_word_t w;
    w       = '0;
    w.valid = 1'b1;
    for (int i = 0; i < FPW; i++) w.data[i].raw = fl[i];
    w.user.flit_valid = vld;
    w.user.flit_hdr   = hdr;
    w.user.flit_tail  = tl;
    w.user.err_rsp    = 4'($urandom);
    rx_w     <= w;
    rsp_next <= exp;
    rdy_next <= rdy;
    @(posedge CLK);
  endtask

  // ---------------------------------------------------------------------------
  // Checks
  // ---------------------------------------------------------------------------
  task automatic end_with_failure();
    failed = 1'b1;
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string what);
    $display("FAILED %0t: %s", $time, what);
    end_with_failure();
  endtask

  a_tx_word: assert property (@(posedge CLK) disable iff (RST) tx_w == exp_tx)
    else report_mismatch("transmit word differs from the expected request flits");
  a_req_ready: assert property (@(posedge CLK) disable iff (RST) req_ready == exp_req_rdy)
    else report_mismatch("req_ready_o differs from the startup and ready model");
  a_rsp: assert property (@(posedge CLK) disable iff (RST)
      rsp.valid == exp_rsp.valid && (!exp_rsp.valid || rsp == exp_rsp))
    else report_mismatch("read response differs in valid, tag, data or error status");
  a_rx_ready: assert property (@(posedge CLK) disable iff (RST) rx_ready == exp_rx_rdy)
    else report_mismatch("rx_ready_o differs from the expected level");
  a_err_resp: assert property (@(posedge CLK) disable iff (RST) error_resp == exp_err)
    else report_mismatch("error_resp_o does not follow the side-band field");

  always @(posedge CLK) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == MAX_CYCLES) begin
      $display("Timeout: the test sequence did not end within %0d cycles", MAX_CYCLES);
      end_with_failure();
    end
  end

  initial begin
    void'($urandom(99641));
    post_done <= 1'b0;
    tx_ready  <= 1'b0;
    wr_req    <= 1'b0;
    wr_addr   <= '0;
    wr_data   <= '0;
    rd_req    <= 1'b0;
    rd_addr   <= '0;
    rd_tag    <= '0;
    rx_w      <= '0;
    rsp_next  <= '0;
    rdy_next  <= 1'b1;
    @(negedge RST);
    @(posedge CLK);
    // Requests before startup never reach the link
    send_req(1'b1, 1'b1);
    post_done <= 1'b1;
    // Ready held high so the settle count alone sets the first req_ready_o
    tx_ready  <= 1'b1;
    repeat (100) idle_cycle('0);
    // Pause in self-test done, settle count holds
    post_done <= 1'b0;
    repeat (10) idle_cycle('0);
    post_done <= 1'b1;
    while (!req_ready) idle_cycle('0);
    // Write, read, then both in one word
    send_req(1'b1, 1'b0);
    send_req(1'b0, 1'b1);
    send_req(1'b1, 1'b1);
    idle_cycle('0);
    // Ready toggling, req_ready_o follows one cycle late
    repeat (16) begin
      tx_ready <= 1'($urandom);
      idle_cycle('0);
    end
    tx_ready <= 1'b1;
    idle_cycle('0);
    // Aligned responses at flit 0 and flit 1
    make_rsp(fa, ra);
    send_word({128'd0, fa[2], fa[1], fa[0]}, 4'b0111, 4'b0001, 4'b0100, ra, 1'b1);
    make_rsp(fa, ra);
    send_word({fa[2], fa[1], fa[0], 128'd0}, 4'b1110, 4'b0010, 4'b1000, ra, 1'b1);
    idle_cycle('0);
    // Flit-2 split, its finishing word starts another flit-2 split
    make_rsp(fa, ra);
    send_word({fa[1], fa[0], 256'd0}, 4'b1100, 4'b0100, 4'b0000, '0, 1'b1);
    make_rsp(fb, rb);
    send_word({fb[1], fb[0], 128'd0, fa[2]}, 4'b1101, 4'b0100, 4'b0001, ra, 1'b1);
    // Finishing word starts a flit-3 split, idle gap before its end
    make_rsp(fa, ra);
    send_word({fa[0], 256'd0, fb[2]}, 4'b1001, 4'b1000, 4'b0001, rb, 1'b1);
    idle_cycle('0);
    send_word({256'd0, fa[2], fa[1]}, 4'b0011, 4'b0000, 4'b0010, ra, 1'b1);
    // Split end plus a full response, link stays silent for one cycle
    make_rsp(fa, ra);
    send_word({fa[1], fa[0], 256'd0}, 4'b1100, 4'b0100, 4'b0000, '0, 1'b1);
    make_rsp(fb, rb);
    send_word({fb[2], fb[1], fb[0], fa[2]}, 4'b1111, 4'b0010, 4'b1001, ra, 1'b0);
    idle_cycle(rb);
    repeat (4) idle_cycle('0);
    if (!failed) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/tb_clock_gen.sv
// Testbench clock and reset source with a 40 ns period and a five-cycle reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic CLK,
  output logic RST
);
  localparam int HALF_PERIOD_NS = 20;
  localparam int RST_CYCLES     = 5;

  initial begin
    CLK = 1'b0;
    forever #(HALF_PERIOD_NS) CLK = ~CLK;
  end

  // Reset released right after the fifth rising edge
  initial begin
    RST = 1'b1;
    repeat (RST_CYCLES) @(posedge CLK);
    RST <= 1'b0;
  end

endmodule

`default_nettype wire

//--- design/hmc_flit_user.sv
// HMC user packet engine top joining link startup, request packer and response unpacker
`timescale 1ns/1ps
`default_nettype none

module hmc_flit_user (
  input  logic                              CLK,
  input  logic                              RST,
  input  logic                              post_done_i,
  // Transmit stream toward the controller
  output hmc_axi_pkg::axis_word_t           tx_o,
  input  logic                              tx_ready_i,
  // Receive stream from the controller
  input  hmc_axi_pkg::axis_word_t           rx_i,
  output logic                              rx_ready_o,
  // User requests
  input  logic                              wr_req_i,
  input  logic [hmc_pkt_pkg::ADDR_W-1:0]    wr_addr_i,
  input  logic [hmc_pkt_pkg::DATA_W-1:0]    wr_data_i,
  input  logic                              rd_req_i,
  input  logic [hmc_pkt_pkg::ADDR_W-1:0]    rd_addr_i,
  input  logic [hmc_pkt_pkg::TAG_W-1:0]     rd_tag_i,
  output logic                              req_ready_o,
  // Read responses and controller error field
  output hmc_axi_pkg::rd_rsp_t              rsp_o,
  output logic [3:0]                        error_resp_o
);

  logic tx_enable;

  hmc_link_startup u_startup (
    .CLK         (CLK),
    .RST         (RST),
    .post_done_i (post_done_i),
    .tx_ready_i  (tx_ready_i),
    .tx_enable_o (tx_enable)
  );

  hmc_req_packer u_packer (
    .CLK         (CLK),
    .RST         (RST),
    .tx_enable_i (tx_enable),
    .tx_ready_i  (tx_ready_i),
    .wr_req_i    (wr_req_i),
    .wr_addr_i   (wr_addr_i),
    .wr_data_i   (wr_data_i),
    .rd_req_i    (rd_req_i),
    .rd_addr_i   (rd_addr_i),
    .rd_tag_i    (rd_tag_i),
    .tx_o        (tx_o),
    .req_ready_o (req_ready_o)
  );

  // Receive side runs independently of the transmit enable
  hmc_rsp_unpacker u_unpacker (
    .CLK          (CLK),
    .RST          (RST),
    .post_done_i  (post_done_i),
    .rx_i         (rx_i),
    .rx_ready_o   (rx_ready_o),
    .rsp_o        (rsp_o),
    .error_resp_o (error_resp_o)
  );

endmodule

`default_nettype wire

//--- design/hmc_rsp_unpacker.sv
// HMC response unpacker that extracts 32-byte read responses from any flit position
`timescale 1ns/1ps
`default_nettype none

module hmc_rsp_unpacker (
  input  logic                     CLK,
  input  logic                     RST,
  input  logic                     post_done_i,
  input  hmc_axi_pkg::axis_word_t  rx_i,
  output logic                     rx_ready_o,
  output hmc_axi_pkg::rd_rsp_t     rsp_o,
  output logic [3:0]               error_resp_o
);
  import hmc_pkt_pkg::*;
  import hmc_axi_pkg::*;

  flit_u [FPW-1:0] d;
  tuser_t          u;
  logic            active_q;
  logic            rx_ready_q;
  logic            dec_fire;
  logic            rsp_at0, rsp_at1, split_at2, split_at3, fin_at2, fin_at3;
  logic            double_rsp;
  logic            pend2_q, pend3_q;
  logic            hold_vld_q;
  rd_rsp_t         hold_rsp_q;
  rd_rsp_t         first_rsp;
  rd_rsp_t         rsp_q;
  logic [3:0]      err_q;
  // Saved header flit and following flit of a split response
  flit_u           part_f0, part_f1;

  // Header flit, middle flit and tail flit into one response
  function automatic rd_rsp_t pack_rsp(input flit_u hf, input flit_u mf, input flit_u tf);
    rd_rsp_t r;
    r.valid   = 1'b1;
    r.tag     = hf.ctl.hdr.tag;
    r.data    = {tf.raw[63:0], mf.raw, hf.raw[127:64]};
    r.errstat = tf.ctl.tail[ERRSTAT_LSB +: ERRSTAT_W];
    return r;
  endfunction

  assign d = rx_i.data;
  assign u = rx_i.user;

  // Decode only accepted words once self-test has been seen
  assign dec_fire = rx_i.valid & rx_ready_q & active_q;

  // ---------------------------------------------------------------------------
  // Flit position matching
  // ---------------------------------------------------------------------------
  // Complete response in flits 0 to 2
  assign rsp_at0 = dec_fire && u.flit_tail[2:0] == 3'b100 && u.flit_hdr[2:0] == 3'b001
                   && u.flit_valid[2:0] == 3'b111;
  // Complete response in flits 1 to 3
  assign rsp_at1 = dec_fire && u.flit_tail[3:1] == 3'b100 && u.flit_hdr[3:1] == 3'b001
                   && u.flit_valid[3:1] == 3'b111;
  // Header at flit 2, tail in the next word
  assign split_at2 = dec_fire && u.flit_tail[3:2] == 2'b00 && u.flit_hdr[3:2] == 2'b01
                     && u.flit_valid[3:2] == 2'b11;
  // Header at flit 3, two more flits in the next word
  assign split_at3 = dec_fire && !u.flit_tail[3] && u.flit_hdr[3] && u.flit_valid[3];
  // Tail of a flit-2 split in flit 0
  assign fin_at2 = dec_fire && pend2_q && u.flit_tail[0] && !u.flit_hdr[0]
                   && u.flit_valid[0];
  // Data and tail of a flit-3 split in flits 0 and 1
  assign fin_at3 = dec_fire && pend3_q && u.flit_tail[1:0] == 2'b10
                   && u.flit_hdr[1:0] == 2'b00 && u.flit_valid[1:0] == 2'b11;

  // Split tail plus a full response in one word
  assign double_rsp = fin_at2 & rsp_at1;

  // Completed split has priority, the flit-1 response then waits in the hold register
  always_comb begin
    first_rsp = '0;
    if (fin_at2) begin
      first_rsp = pack_rsp(part_f0, part_f1, d[0]);
    end else if (fin_at3) begin
      first_rsp = pack_rsp(part_f0, d[0], d[1]);
    end else if (rsp_at0) begin
      first_rsp = pack_rsp(d[0], d[1], d[2]);
    end else if (rsp_at1) begin
      first_rsp = pack_rsp(d[1], d[2], d[3]);
    end
  end

  // ---------------------------------------------------------------------------
  // Control and output registers
  // ---------------------------------------------------------------------------
  always_ff @(posedge CLK) begin
    if (RST) begin
      active_q   <= 1'b0;
      rx_ready_q <= 1'b0;
      pend2_q    <= 1'b0;
      pend3_q    <= 1'b0;
      hold_vld_q <= 1'b0;
      rsp_q      <= '0;
      err_q      <= '0;
    end else begin
      active_q   <= active_q | post_done_i;
      rx_ready_q <= 1'b1;
      hold_vld_q <= 1'b0;
      rsp_q.valid <= 1'b0;
      if (dec_fire) begin
        err_q <= u.err_rsp;
      end
      if (hold_vld_q) begin
        rsp_q <= hold_rsp_q;
      end else if (first_rsp.valid) begin
        rsp_q <= first_rsp;
      end
      // Stall the link one cycle to drain the second response
      if (double_rsp) begin
        hold_vld_q <= 1'b1;
        rx_ready_q <= 1'b0;
      end
      // A new split start re-arms even when a split finishes in the same word
      if (split_at2) begin
        pend2_q <= 1'b1;
        pend3_q <= 1'b0;
      end else if (split_at3) begin
        pend3_q <= 1'b1;
        pend2_q <= 1'b0;
      end else begin
        if (fin_at2) pend2_q <= 1'b0;
        if (fin_at3) pend3_q <= 1'b0;
      end
    end
  end

  // Partial flits and the held response
  always_ff @(posedge CLK) begin
    if (split_at2) begin
      part_f0 <= d[2];
      part_f1 <= d[3];
    end else if (split_at3) begin
      part_f0 <= d[3];
    end
    if (double_rsp) begin
      hold_rsp_q <= pack_rsp(d[1], d[2], d[3]);
    end
  end

  assign rx_ready_o   = rx_ready_q;
  assign rsp_o        = rsp_q;
  assign error_resp_o = err_q;

endmodule

`default_nettype wire

//--- design/hmc_req_packer.sv
// HMC request packer that places posted-write and read flits into one transmit word
`timescale 1ns/1ps
`default_nettype none

module hmc_req_packer (
  input  logic                              CLK,
  input  logic                              RST,
  input  logic                              tx_enable_i,
  input  logic                              tx_ready_i,
  input  logic                              wr_req_i,
  input  logic [hmc_pkt_pkg::ADDR_W-1:0]    wr_addr_i,
  input  logic [hmc_pkt_pkg::DATA_W-1:0]    wr_data_i,
  input  logic                              rd_req_i,
  input  logic [hmc_pkt_pkg::ADDR_W-1:0]    rd_addr_i,
  input  logic [hmc_pkt_pkg::TAG_W-1:0]     rd_tag_i,
  output hmc_axi_pkg::axis_word_t           tx_o,
  output logic                              req_ready_o
);
  import hmc_pkt_pkg::*;
  import hmc_axi_pkg::*;

  axis_word_t tx_q;
  logic       req_ready_q;

  // Request header with cube and reserved bits at zero
  function automatic req_hdr_t build_hdr(
    input logic [ADDR_W-1:0] addr,
    input logic [TAG_W-1:0]  tag,
    input logic [3:0]        lng,
    input logic [5:0]        cmd
  );
    req_hdr_t h;
    h      = '0;
    // Address in 32-byte units, upper two bits reserved
    h.addr = {2'b00, addr, 5'b00000};
    h.tag  = tag;
    h.dln  = lng;
    h.lng  = lng;
    h.cmd  = cmd;
    return h;
  endfunction

  // ---------------------------------------------------------------------------
  // Transmit word, one cycle after the request
  // ---------------------------------------------------------------------------
  always_ff @(posedge CLK) begin
    if (RST) begin
      tx_q        <= '0;
      req_ready_q <= 1'b0;
    end else begin
      // Idle cycles send an all-zero word
      tx_q        <= '0;
      req_ready_q <= tx_enable_i & tx_ready_i;
      if (tx_enable_i) begin
        tx_q.valid <= wr_req_i | rd_req_i;
        // Posted write fills flits 0 to 2
        if (wr_req_i) begin
          tx_q.data[0].raw <= {wr_data_i[63:0],
                               build_hdr(wr_addr_i, WR_TAG, LNG_WR32, CMD_P_WR32)};
          tx_q.data[1].raw <= wr_data_i[191:64];
          // Zero tail above the last data bits
          tx_q.data[2].raw <= {64'd0, wr_data_i[255:192]};
          tx_q.user.flit_valid[2:0] <= 3'b111;
          tx_q.user.flit_hdr[0]     <= 1'b1;
          tx_q.user.flit_tail[2]    <= 1'b1;
        end
        // Read is a single flit in flit 3
        if (rd_req_i) begin
          tx_q.data[3].ctl.hdr  <= build_hdr(rd_addr_i, rd_tag_i, LNG_RD32, CMD_RD32);
          tx_q.data[3].ctl.tail <= '0;
          tx_q.user.flit_valid[3] <= 1'b1;
          tx_q.user.flit_hdr[3]   <= 1'b1;
          tx_q.user.flit_tail[3]  <= 1'b1;
        end
      end
    end
  end

  assign tx_o        = tx_q;
  // Follows controller ready one cycle late
  assign req_ready_o = req_ready_q;

endmodule

`default_nettype wire

//--- design/hmc_link_startup.sv
// HMC link startup that waits for self-test and settling, then enables requests
`timescale 1ns/1ps
`default_nettype none

module hmc_link_startup (
  input  logic CLK,
  input  logic RST,
  input  logic post_done_i,
  input  logic tx_ready_i,
  output logic tx_enable_o
);
  import hmc_axi_pkg::*;

  typedef enum logic [1:0] {
    ST_SETTLE,
    ST_WAIT_RDY,
    ST_ACTIVE
  } state_t;

  state_t                            state_q;
  logic [$clog2(STARTUP_WAIT)-1:0]   settle_cnt_q;
  logic                              settle_done;

  // Last settle cycle, counting only cycles with self-test done
  assign settle_done = post_done_i && (32'(settle_cnt_q) == STARTUP_WAIT - 1);

  always_ff @(posedge CLK) begin
    if (RST) begin
      state_q      <= ST_SETTLE;
      settle_cnt_q <= '0;
    end else begin
      case (state_q)
        ST_SETTLE: begin
          if (post_done_i) begin
            settle_cnt_q <= settle_cnt_q + 1'b1;
          end
          if (settle_done) begin
            state_q <= ST_WAIT_RDY;
          end
        end
        // Controller must show ready once before the first request
        ST_WAIT_RDY: begin
          if (tx_ready_i) begin
            state_q <= ST_ACTIVE;
          end
        end
        ST_ACTIVE: state_q <= ST_ACTIVE;
        default:   state_q <= ST_SETTLE;
      endcase
    end
  end

  // Stays high until reset
  assign tx_enable_o = (state_q == ST_ACTIVE);

endmodule

`default_nettype wire

//--- design/hmc_axi_pkg.sv
// HMC AXI-stream definitions for the word layout, side-band flags and startup timing
`default_nettype none

package hmc_axi_pkg;

  // Four flits per 512-bit word
  localparam int FPW = 4;

  // Cycles with self-test done before requests may go out
  localparam int STARTUP_WAIT = 256;

  // ---------------------------------------------------------------------------
  // Side-band, one flag per flit in each nibble
  // ---------------------------------------------------------------------------
  typedef struct packed {
    logic [47:0]    rsvd;
    logic [3:0]     err_rsp;     // Error response from the controller
    logic [FPW-1:0] flit_tail;
    logic [FPW-1:0] flit_hdr;
    logic [FPW-1:0] flit_valid;
  } tuser_t;

  // Flit 0 sits in the lowest lanes and is processed first
  typedef struct packed {
    logic                           valid;
    hmc_pkt_pkg::flit_u [FPW-1:0]   data;
    tuser_t                         user;
  } axis_word_t;

  // One decoded read response
  typedef struct packed {
    logic                             valid;
    logic [hmc_pkt_pkg::TAG_W-1:0]    tag;
    logic [hmc_pkt_pkg::DATA_W-1:0]   data;
    logic [hmc_pkt_pkg::ERRSTAT_W-1:0] errstat;
  } rd_rsp_t;

endpackage

`default_nettype wire

//--- design/hmc_pkt_pkg.sv
// HMC packet definitions for request headers, commands, tail fields and the flit views
`default_nettype none

package hmc_pkt_pkg;

  // ---------------------------------------------------------------------------
  // Basic widths
  // ---------------------------------------------------------------------------
  localparam int FLIT_W = 128;
  // User address counts 32-byte blocks
  localparam int ADDR_W = 27;
  localparam int TAG_W  = 9;
  localparam int DATA_W = 256;

  // Request commands
  localparam logic [5:0] CMD_P_WR32 = 6'b011001;
  localparam logic [5:0] CMD_RD32   = 6'b110001;

  // Packet lengths in flits, also used for the duplicate length field
  localparam logic [3:0] LNG_WR32 = 4'd3;
  localparam logic [3:0] LNG_RD32 = 4'd1;

  // Posted writes get no response so the tag is fixed
  localparam logic [TAG_W-1:0] WR_TAG = 9'd1;

  // Error status position inside the response tail
  localparam int ERRSTAT_LSB = 20;
  localparam int ERRSTAT_W   = 7;

  // ---------------------------------------------------------------------------
  // Request header, MSB first
  // ---------------------------------------------------------------------------
  typedef struct packed {
    logic [2:0]       cub;
    logic [2:0]       res_hi;
    logic [33:0]      addr;     // 2 zero bits, user address, 5 zero bits
    logic [TAG_W-1:0] tag;
    logic [3:0]       dln;
    logic [3:0]       lng;
    logic             res_lo;
    logic [5:0]       cmd;
  } req_hdr_t;

  // Control view with header in the low half and tail in the high half
  typedef struct packed {
    logic [63:0] tail;
    req_hdr_t    hdr;
  } ctl_flit_t;

  // Header flits and data flits travel on the same lanes
  typedef union packed {
    ctl_flit_t         ctl;
    logic [FLIT_W-1:0] raw;
  } flit_u;

endpackage

`default_nettype wire
